// ==== Makefile ====
TOP = tb_mem_subsys

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f $(wildcard common/*.sv hdl/*.sv sram/*.sv sim/*.sv sim/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // Bus geometry
    localparam int ADDR_W    = 32;          // Byte address
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;  // One enable per byte lane

    // SRAM geometry
    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = 8;           // log2 of MEM_WORDS

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    localparam int N_MASTERS = 2;           // Fetch side and load/store side

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;
    typedef logic [IDX_W-1:0]  idx_t;

    // Write address and data travel as one beat
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;    // Byte enables
    } axil_wreq_t;

    // Read response payload
    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_rresp_t;

    // One SRAM command, held by the bridge until answered
    typedef struct packed {
        idx_t  idx;     // Word index
        data_t data;    // Write data, ignored on reads
        strb_t mask;    // Byte mask for writes
        logic  wr;      // 1 write, 0 read
    } sram_req_t;

endpackage

// ==== flist.f ====
+incdir+sim
common/mem_pkg.sv
hdl/axil_arbiter.sv
sram/sram_axil_bridge.sv
sram/sram_array.sv
hdl/mem_subsys_top.sv
sim/mem_subsys_checker.sv
sim/tb_mem_subsys.sv

// ==== hdl/axil_arbiter.sv ====
`timescale 1ns/1ps

module axil_arbiter import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // Master side
    input  logic        m_wvalid  [N_MASTERS],
    input  axil_wreq_t  m_wreq    [N_MASTERS],
    output logic        m_wready  [N_MASTERS],
    input  logic        m_arvalid [N_MASTERS],
    input  addr_t       m_araddr  [N_MASTERS],
    output logic        m_arready [N_MASTERS],
    output logic        m_bvalid  [N_MASTERS],
    output resp_t       m_bresp   [N_MASTERS],
    input  logic        m_bready  [N_MASTERS],
    output logic        m_rvalid  [N_MASTERS],
    output axil_rresp_t m_r       [N_MASTERS],
    input  logic        m_rready  [N_MASTERS],

    // Slave side
    output logic        s_wvalid,
    output axil_wreq_t  s_wreq,
    input  logic        s_wready,
    output logic        s_arvalid,
    output addr_t       s_araddr,
    input  logic        s_arready,
    input  logic        s_bvalid,
    input  resp_t       s_bresp,
    output logic        s_bready,
    input  logic        s_rvalid,
    input  axil_rresp_t s_r,
    output logic        s_rready
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY    // Locked until the b or r handshake
    } arb_state_t;

    arb_state_t state;
    logic       gnt_q;      // Locked master
    logic       last_q;     // Master served last
    logic       req0;
    logic       req1;
    logic       pick;       // Idle-time choice
    logic       sel;        // Master routed to the slave this cycle
    logic       accept;
    logic       done;

    assign req0 = m_wvalid[0] | m_arvalid[0];
    assign req1 = m_wvalid[1] | m_arvalid[1];

    // Round robin, the master not served last wins a tie
    always_comb begin
        if (req0 && req1) begin
            pick = ~last_q;
        end else begin
            pick = req1;    // Lone requester, or 0 when quiet
        end
    end

    assign sel = (state == ARB_IDLE) ? pick : gnt_q;

    // Request path, closed while locked
    assign s_wvalid  = (state == ARB_IDLE) && m_wvalid[sel];
    assign s_arvalid = (state == ARB_IDLE) && m_arvalid[sel];
    assign s_wreq    = m_wreq[sel];
    assign s_araddr  = m_araddr[sel];
    assign s_bready  = m_bready[sel];
    assign s_rready  = m_rready[sel];

    assign accept = (s_wvalid && s_wready) || (s_arvalid && s_arready);
    assign done   = (s_bvalid && s_bready) || (s_rvalid && s_rready);

    // Steer readies and responses to the selected master only
    for (genvar i = 0; i < N_MASTERS; i++) begin : g_steer
        assign m_wready[i]  = (sel == 1'(i)) && (state == ARB_IDLE) && s_wready;
        assign m_arready[i] = (sel == 1'(i)) && (state == ARB_IDLE) && s_arready;
        assign m_bvalid[i]  = (sel == 1'(i)) && s_bvalid;
        assign m_rvalid[i]  = (sel == 1'(i)) && s_rvalid;
        assign m_bresp[i]   = s_bresp;      // Payload shared, valid qualifies it
        assign m_r[i]       = s_r;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ARB_IDLE;
            gnt_q  <= 1'b0;
            last_q <= 1'b1;         // Master 0 first after reset
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (accept) begin
                        state  <= ARB_BUSY;
                        gnt_q  <= pick;
                        last_q <= pick;
                    end
                end
                ARB_BUSY: begin
                    if (done) state <= ARB_IDLE;    // Lock released on response
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // Port 0 fetch, port 1 load/store
    input  logic        m_wvalid  [N_MASTERS],
    input  axil_wreq_t  m_wreq    [N_MASTERS],
    output logic        m_wready  [N_MASTERS],
    input  logic        m_arvalid [N_MASTERS],
    input  addr_t       m_araddr  [N_MASTERS],
    output logic        m_arready [N_MASTERS],
    output logic        m_bvalid  [N_MASTERS],
    output resp_t       m_bresp   [N_MASTERS],
    input  logic        m_bready  [N_MASTERS],
    output logic        m_rvalid  [N_MASTERS],
    output axil_rresp_t m_r       [N_MASTERS],
    input  logic        m_rready  [N_MASTERS]
);

    // Arbiter to bridge
    logic        s_wvalid;
    axil_wreq_t  s_wreq;
    logic        s_wready;
    logic        s_arvalid;
    addr_t       s_araddr;
    logic        s_arready;
    logic        s_bvalid;
    resp_t       s_bresp;
    logic        s_bready;
    logic        s_rvalid;
    axil_rresp_t s_r;
    logic        s_rready;

    // Bridge to SRAM
    logic        sram_req_valid;
    sram_req_t   sram_req;
    logic        sram_resp_valid;
    data_t       sram_rdata;

    axil_arbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .m_wvalid  (m_wvalid),
        .m_wreq    (m_wreq),
        .m_wready  (m_wready),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arready (m_arready),
        .m_bvalid  (m_bvalid),
        .m_bresp   (m_bresp),
        .m_bready  (m_bready),
        .m_rvalid  (m_rvalid),
        .m_r       (m_r),
        .m_rready  (m_rready),
        .s_wvalid  (s_wvalid),
        .s_wreq    (s_wreq),
        .s_wready  (s_wready),
        .s_arvalid (s_arvalid),
        .s_araddr  (s_araddr),
        .s_arready (s_arready),
        .s_bvalid  (s_bvalid),
        .s_bresp   (s_bresp),
        .s_bready  (s_bready),
        .s_rvalid  (s_rvalid),
        .s_r       (s_r),
        .s_rready  (s_rready)
    );

    sram_axil_bridge i_bridge (
        .clk             (clk),
        .rst             (rst),
        .wvalid          (s_wvalid),
        .wreq            (s_wreq),
        .wready          (s_wready),
        .arvalid         (s_arvalid),
        .araddr          (s_araddr),
        .arready         (s_arready),
        .bvalid          (s_bvalid),
        .bresp           (s_bresp),
        .bready          (s_bready),
        .rvalid          (s_rvalid),
        .r               (s_r),
        .rready          (s_rready),
        .sram_req_valid  (sram_req_valid),
        .sram_req        (sram_req),
        .sram_resp_valid (sram_resp_valid),
        .sram_rdata      (sram_rdata)
    );

    sram_array i_sram (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (sram_req_valid),
        .req        (sram_req),
        .resp_valid (sram_resp_valid),
        .rdata      (sram_rdata)
    );

endmodule

// ==== sim/mem_subsys_checker.sv ====
`timescale 1ns/1ps

module mem_subsys_checker import mem_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        wvalid,
    input axil_wreq_t  wreq,
    input logic        wready,
    input logic        arvalid,
    input addr_t       araddr,
    input logic        arready,
    input logic        bvalid,
    input resp_t       bresp,
    input logic        bready,
    input logic        rvalid,
    input axil_rresp_t r,
    input logic        rready,
    input logic        in_idle,     // Bridge FSM in BR_IDLE
    input logic        sram_req_valid,
    input sram_req_t   sram_req,
    input logic        sram_resp_valid
);

    int unsigned fail_cnt = 0;

    // Request channels hold until taken
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wreq))
        else begin
            fail_cnt++;
            $error("write request dropped or changed before wready");
        end
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_cnt++;
            $error("read address dropped or changed before arready");
        end

    // Responses hold under back-pressure
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_cnt++;
            $error("write response dropped or changed before bready");
        end
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r))
        else begin
            fail_cnt++;
            $error("read response dropped or changed before rready");
        end

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(bvalid && rvalid))
        else begin
            fail_cnt++;
            $error("bvalid and rvalid high together");
        end

    a_busy_ready: assert property (@(posedge clk) disable iff (rst)
        !in_idle |-> !wready && !arready)
        else begin
            fail_cnt++;
            $error("ready high while bridge busy");
        end

    // SRAM command frozen until answered
    a_sram_hold: assert property (@(posedge clk) disable iff (rst)
        sram_req_valid && !sram_resp_valid |=> sram_req_valid && $stable(sram_req))
        else begin
            fail_cnt++;
            $error("SRAM request changed before resp_valid");
        end

endmodule

bind sram_axil_bridge mem_subsys_checker i_checker (
    .clk             (clk),
    .rst             (rst),
    .wvalid          (wvalid),
    .wreq            (wreq),
    .wready          (wready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .rvalid          (rvalid),
    .r               (r),
    .rready          (rready),
    .in_idle         (state == BR_IDLE),
    .sram_req_valid  (sram_req_valid),
    .sram_req        (sram_req),
    .sram_resp_valid (sram_resp_valid)
);

// ==== sim/tb_axil_bfm.svh ====
// Master-side drivers for one port, shared by both ports

// A stalled channel ends all further traffic
task automatic note_timeout(input int p, input string chan);
    hung = 1'b1;
    errors++;
    $display("timeout: port %0d waited %0d cycles on the %s channel", p, TIMEOUT_CYC, chan);
endtask

task automatic write_word(input int p, input axil_wreq_t req, input int hold,
                          output resp_t resp, output bit ok);
    int n;
    ok   = 1'b0;
    resp = '0;
    if (hung) return;
    ops_sent[p]++;
    m_wreq[p]   = req;
    m_wvalid[p] = 1'b1;
    n = 0;
    @(negedge clk);
    while (!m_wready[p]) begin              // Needs the grant and an idle bridge
        n++;
        if (n > TIMEOUT_CYC) begin
            m_wvalid[p] = 1'b0;
            note_timeout(p, "write request");
            return;
        end
        @(negedge clk);
    end
    @(posedge clk);                         // Handshake edge
    #2;
    m_wvalid[p] = 1'b0;
    m_bready[p] = (hold == 0);              // Ready early when not holding back
    n = 0;
    @(negedge clk);
    while (!m_bvalid[p]) begin
        n++;
        if (n > TIMEOUT_CYC) begin
            m_bready[p] = 1'b0;
            note_timeout(p, "write response");
            return;
        end
        @(negedge clk);
    end
    resp = m_bresp[p];
    for (int k = 0; k < hold; k++) begin
        @(posedge clk);                     // Edge stalled by bready low
        #2;
        if (k == hold - 1) m_bready[p] = 1'b1;
        @(negedge clk);
        if (!m_bvalid[p] || m_bresp[p] !== resp) begin
            errors++;
            $display("ERR @%0t: port %0d write response dropped or changed while held back",
                     $time, p);
        end
    end
    @(posedge clk);                         // Response handshake
    #2;
    m_bready[p] = 1'b0;
    ok = 1'b1;
endtask

task automatic read_word(input int p, input addr_t addr, input int hold,
                         output axil_rresp_t rr, output bit ok);
    int n;
    ok = 1'b0;
    rr = '0;
    if (hung) return;
    ops_sent[p]++;
    m_araddr[p]  = addr;
    m_arvalid[p] = 1'b1;
    n = 0;
    @(negedge clk);
    while (!m_arready[p]) begin
        n++;
        if (n > TIMEOUT_CYC) begin
            m_arvalid[p] = 1'b0;
            note_timeout(p, "read address");
            return;
        end
        @(negedge clk);
    end
    @(posedge clk);
    #2;
    m_arvalid[p] = 1'b0;
    m_rready[p]  = (hold == 0);
    n = 0;
    @(negedge clk);
    while (!m_rvalid[p]) begin
        n++;
        if (n > TIMEOUT_CYC) begin
            m_rready[p] = 1'b0;
            note_timeout(p, "read data");
            return;
        end
        @(negedge clk);
    end
    rr = m_r[p];
    for (int k = 0; k < hold; k++) begin
        @(posedge clk);
        #2;
        if (k == hold - 1) m_rready[p] = 1'b1;
        @(negedge clk);
        if (!m_rvalid[p] || m_r[p] !== rr) begin      // Data and resp both held
            errors++;
            $display("ERR @%0t: port %0d read response dropped or changed while held back",
                     $time, p);
        end
    end
    @(posedge clk);
    #2;
    m_rready[p] = 1'b0;
    ok = 1'b1;
endtask

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int TIMEOUT_CYC = 200;   // Per wait loop

    logic        clk;
    logic        rst;
    logic        m_wvalid  [N_MASTERS];
    axil_wreq_t  m_wreq    [N_MASTERS];
    logic        m_wready  [N_MASTERS];
    logic        m_arvalid [N_MASTERS];
    addr_t       m_araddr  [N_MASTERS];
    logic        m_arready [N_MASTERS];
    logic        m_bvalid  [N_MASTERS];
    resp_t       m_bresp   [N_MASTERS];
    logic        m_bready  [N_MASTERS];
    logic        m_rvalid  [N_MASTERS];
    axil_rresp_t m_r       [N_MASTERS];
    logic        m_rready  [N_MASTERS];

    data_t ref_mem [MEM_WORDS];     // Reference memory in b commit order
    int    seed;
    int    errors;
    int    checks;
    bit    hung;
    int    ops_sent  [N_MASTERS];
    int    resp_seen [N_MASTERS];   // Response handshakes seen on the bus
    int    passed    [N_MASTERS];   // Grants to the other port while waiting
    bit    pending   [N_MASTERS];   // Request accepted, response not yet taken

    mem_subsys_top i_dut (.*);

    `include "tb_axil_bfm.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic bit in_range(input addr_t a);
        return a[ADDR_W-1:2] < MEM_WORDS;
    endfunction

    function automatic data_t merge(input data_t old, input data_t nw, input strb_t m);
        data_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (m[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    // Small window of words so reads often hit earlier writes
    function automatic addr_t rand_addr();
        idx_t i;
        i = idx_t'($random(seed)) & 8'h1f;
        return addr_t'({i, 2'b00});
    endfunction

    task automatic check_resp(input resp_t got, input resp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s response %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rdata(input data_t got, input data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s data %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic do_write(input int p, input addr_t a, input data_t d, input strb_t s,
                            input int hold);
        axil_wreq_t req;
        resp_t      resp;
        bit         ok;
        req = '{addr: a, data: d, strb: s};
        write_word(p, req, hold, resp, ok);
        if (!ok) return;
        if (in_range(a)) begin
            ref_mem[a[IDX_W+1:2]] = merge(ref_mem[a[IDX_W+1:2]], d, s);
            check_resp(resp, RESP_OKAY, $sformatf("port %0d write %h", p, a));
        end else begin
            // Model untouched
            check_resp(resp, RESP_SLVERR, $sformatf("port %0d write %h", p, a));
        end
    endtask

    task automatic do_read(input int p, input addr_t a, input int hold);
        axil_rresp_t rr;
        bit          ok;
        read_word(p, a, hold, rr, ok);
        if (!ok) return;
        if (in_range(a)) begin
            check_resp(rr.resp, RESP_OKAY, $sformatf("port %0d read %h", p, a));
            check_rdata(rr.data, ref_mem[a[IDX_W+1:2]], $sformatf("port %0d read %h", p, a));
        end else begin
            check_resp(rr.resp, RESP_SLVERR, $sformatf("port %0d read %h", p, a));
            check_rdata(rr.data, '0, $sformatf("port %0d read %h", p, a));
        end
    endtask

    task automatic random_ops(input int p, input int n, input bit pressure);
        addr_t a;
        int    hold;
        for (int i = 0; i < n; i++) begin
            a    = rand_addr();
            hold = pressure ? int'($unsigned($random(seed)) % 6) : 0;
            if ($random(seed) & 1) do_write(p, a, $random(seed), strb_t'($random(seed)), hold);
            else do_read(p, a, hold);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %-28s done, %0d errors", name, errors - mark);
    endtask

    // Response counting and grant fairness sampled mid-cycle
    always @(negedge clk) begin
        logic acc [N_MASTERS];
        if (!rst) begin
            for (int p = 0; p < N_MASTERS; p++) begin
                acc[p] = (m_wvalid[p] && m_wready[p]) || (m_arvalid[p] && m_arready[p]);
                if ((m_bvalid[p] || m_rvalid[p]) && !pending[p]) begin  // Stray or repeated
                    errors++;
                    $display("port %0d got a response with no request in flight", p);
                end
                if ((m_bvalid[p] && m_bready[p]) || (m_rvalid[p] && m_rready[p])) begin
                    resp_seen[p]++;
                    pending[p] = 1'b0;
                end
                if (acc[p]) pending[p] = 1'b1;
            end
            for (int q = 0; q < N_MASTERS; q++) begin
                if (!(m_wvalid[q] || m_arvalid[q]) || acc[q]) begin
                    passed[q] = 0;
                end else if (acc[1-q]) begin
                    passed[q]++;
                    if (passed[q] > 1) begin                // Skipped twice in a row
                        errors++;
                        $display("port %0d waited through two grants to port %0d", q, 1 - q);
                    end
                end
            end
        end
    end

    initial begin
        addr_t a;
        data_t d;
        int    mark;
        seed   = 32'h7236;
        errors = 0;
        checks = 0;
        hung   = 1'b0;
        rst    = 1'b1;
        for (int p = 0; p < N_MASTERS; p++) begin
            m_wvalid[p]  = 1'b0;
            m_wreq[p]    = '0;
            m_arvalid[p] = 1'b0;
            m_araddr[p]  = '0;
            m_bready[p]  = 1'b0;
            m_rready[p]  = 1'b0;
            ops_sent[p]  = 0;
            resp_seen[p] = 0;
            passed[p]    = 0;
            pending[p]   = 1'b0;
        end
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;   // SRAM starts cleared
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        mark = errors;
        for (int p = 0; p < N_MASTERS; p++) begin
            for (int i = 0; i < 4; i++) begin
                a = rand_addr();
                d = $random(seed);
                do_write(p, a, d, 4'hf, 0);
                do_read(p, a, 0);
            end
        end
        report_test("full word write and read", mark);

        mark = errors;
        for (int i = 0; i < 20; i++) begin
            a = rand_addr();
            do_write(i % 2, a, $random(seed), strb_t'($random(seed)), 0);
            do_read(1 - i % 2, a, 0);           // Read back from the other port
        end
        report_test("partial strobes", mark);

        mark = errors;
        for (int i = 0; i < 6; i++) begin
            a = (addr_t'($random(seed)) & 32'hffff_fffc) | 32'h400;    // Word index >= 256
            do_write(i % 2, a, $random(seed), 4'hf, 0);
            do_read(i % 2, a, 0);
            do_read(i % 2, addr_t'({a[IDX_W+1:2], 2'b00}), 0);         // Aliased word intact
        end
        report_test("out of range", mark);

        mark = errors;
        fork
            random_ops(0, 150, 1'b0);
            random_ops(1, 150, 1'b0);
        join
        report_test("concurrent random traffic", mark);

        mark = errors;
        fork
            random_ops(0, 40, 1'b1);
            random_ops(1, 40, 1'b1);
        join
        for (int p = 0; p < N_MASTERS; p++) begin
            if (ops_sent[p] != resp_seen[p]) begin
                errors++;
                $display("port %0d issued %0d requests but saw %0d responses",
                         p, ops_sent[p], resp_seen[p]);
            end
        end
        report_test("random back-pressure", mark);

        errors += i_dut.i_bridge.i_checker.fail_cnt;    // Assertion failures
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sram/sram_array.sv ====
`timescale 1ns/1ps

module sram_array import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  sram_req_t req,
    output logic      resp_valid,
    output data_t     rdata
);

    data_t      mem [MEM_WORDS];
    logic [7:0] lfsr;
    logic       req_q;      // req_valid last cycle, for edge detect
    logic       busy;
    logic [1:0] cnt;        // Wait cycles left
    logic       start;
    logic       fire;       // Access this cycle

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // New command only on the rise of req_valid
    assign start = req_valid && !req_q;
    // Zero wait answers on the next cycle
    assign fire  = (start && lfsr[1:0] == 2'd0) || (busy && cnt == 2'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr       <= 8'hA5;
            req_q      <= 1'b0;
            busy       <= 1'b0;
            cnt        <= '0;
            resp_valid <= 1'b0;
        end else begin
            lfsr       <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // x^8+x^6+x^5+x^4+1
            req_q      <= req_valid;
            resp_valid <= fire;                 // One-cycle pulse
            if (start && lfsr[1:0] != 2'd0) begin
                busy <= 1'b1;
                cnt  <= lfsr[1:0];
            end else if (busy) begin
                if (cnt == 2'd1) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end
        end
    end

    // Array access, byte masked on writes
    always_ff @(posedge clk) begin
        if (fire) begin
            if (req.wr) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (req.mask[b]) mem[req.idx][8*b +: 8] <= req.data[8*b +: 8];
                end
            end else begin
                rdata <= mem[req.idx];
            end
        end
    end

endmodule

// ==== sram/sram_axil_bridge.sv ====
`timescale 1ns/1ps

module sram_axil_bridge import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // AXI4-Lite slave, AW and W merged
    input  logic        wvalid,
    input  axil_wreq_t  wreq,
    output logic        wready,
    input  logic        arvalid,
    input  addr_t       araddr,
    output logic        arready,
    output logic        bvalid,
    output resp_t       bresp,
    input  logic        bready,
    output logic        rvalid,
    output axil_rresp_t r,
    input  logic        rready,

    // SRAM command and answer
    output logic        sram_req_valid,
    output sram_req_t   sram_req,
    input  logic        sram_resp_valid,
    input  data_t       sram_rdata
);

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_WRITE,   // SRAM write in flight
        BR_READ,    // SRAM read in flight
        BR_RESP     // Holding b or r for the master
    } br_state_t;

    br_state_t           state;
    logic                live;      // Low during the first cycle after reset
    logic                wr_q;      // Transaction kind, picks b or r
    logic                w_acc;
    logic                r_acc;
    addr_t               acc_addr;
    logic [ADDR_W-3:0]   acc_word;
    logic                acc_err;

    // Captured request and response payload
    idx_t                idx_q;
    data_t               data_q;
    strb_t               strb_q;
    resp_t               resp_q;
    data_t               rdata_q;

    assign wready  = live && (state == BR_IDLE);
    assign arready = live && (state == BR_IDLE) && !wvalid;   // Write goes first
    assign w_acc   = wvalid && wready;
    assign r_acc   = arvalid && arready;

    // Range decode on the accepted address
    assign acc_addr = w_acc ? wreq.addr : araddr;
    assign acc_word = acc_addr[ADDR_W-1:2];
    assign acc_err  = acc_word >= MEM_WORDS;

    assign sram_req_valid = (state == BR_WRITE) || (state == BR_READ);
    assign sram_req       = '{idx: idx_q, data: data_q, mask: strb_q, wr: wr_q};

    assign bvalid = (state == BR_RESP) && wr_q;
    assign rvalid = (state == BR_RESP) && !wr_q;
    assign bresp  = resp_q;
    assign r      = '{data: rdata_q, resp: resp_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= BR_IDLE;
            live  <= 1'b0;
            wr_q  <= 1'b0;
        end else begin
            live <= 1'b1;
            case (state)
                BR_IDLE: begin
                    if (w_acc) begin
                        wr_q  <= 1'b1;
                        state <= acc_err ? BR_RESP : BR_WRITE;  // Bad address skips SRAM
                    end else if (r_acc) begin
                        wr_q  <= 1'b0;
                        state <= acc_err ? BR_RESP : BR_READ;
                    end
                end
                BR_WRITE, BR_READ: begin
                    if (sram_resp_valid) state <= BR_RESP;
                end
                BR_RESP: begin
                    if ((bvalid && bready) || (rvalid && rready)) state <= BR_IDLE;
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (w_acc || r_acc) begin
            idx_q   <= acc_addr[IDX_W+1:2];
            data_q  <= wreq.data;
            strb_q  <= w_acc ? wreq.strb : '0;
            resp_q  <= acc_err ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= '0;                          // Zero data on SLVERR reads
        end else if (state == BR_READ && sram_resp_valid) begin
            rdata_q <= sram_rdata;
        end
    end

endmodule
